// ==== rtl/disp_params.svh ====
`ifndef DISP_PARAMS_SVH
`define DISP_PARAMS_SVH

// cycles each digit stays selected before the scan moves on
`define DISP_SCAN_TICKS 3

// digit positions on the board, position 0 is the rightmost
`define DISP_DIGITS 6

// record buffer entries, also the credits the writer holds after reset
`define DISP_FIFO_DEPTH 4

`endif

// ==== rtl/disp_pkg.sv ====
`default_nettype none

`include "disp_params.svh"

package disp_pkg;

	typedef logic [7:0] seg_t; // active low, bit 7 is the dp
	typedef logic [`DISP_DIGITS-1:0] sel_t; // active low, bit k selects digit k
	typedef seg_t [`DISP_DIGITS-1:0] digit_array_t; // indexed by digit position

	localparam seg_t SEG_BLANK = 8'b1111_1111; // every segment off
	localparam seg_t SEG_ZERO  = 8'b1100_0000;

	// common-anode patterns for the decimal digits, anything else goes dark
	function automatic seg_t seg_decode(input logic [3:0] digit);
		case (digit)
			4'd0:    return SEG_ZERO;
			4'd1:    return 8'b1111_1001;
			4'd2:    return 8'b1010_0100;
			4'd3:    return 8'b1011_0000;
			4'd4:    return 8'b1001_1001;
			4'd5:    return 8'b1001_0010;
			4'd6:    return 8'b1000_0010;
			4'd7:    return 8'b1111_1000;
			4'd8:    return 8'b1000_0000;
			4'd9:    return 8'b1001_0000;
			default: return SEG_BLANK;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== rtl/flow_pkg.sv ====
`default_nettype none

`include "disp_params.svh"

package flow_pkg;

	typedef enum logic {
		REC_VALUE   = 1'b0,
		REC_PATTERN = 1'b1
	} rec_kind_t;

	// one byte, read as a number or as raw segments depending on kind
	typedef union packed {
		logic [7:0]     value; // binary 0 to 255
		disp_pkg::seg_t pattern; // shown as is on digit 0
	} rec_payload_u;

	typedef struct packed {
		rec_kind_t    kind;
		rec_payload_u payload;
	} rec_t;

	typedef logic [$clog2(`DISP_FIFO_DEPTH+1)-1:0] credit_t; // 0 to depth inclusive

endpackage

`default_nettype wire

// ==== rtl/host_writer.sv ====
`default_nettype none

`include "disp_params.svh"

module host_writer (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                wr_en,
	input  flow_pkg::rec_kind_t wr_kind,
	input  logic [7:0]          wr_data,
	output logic                wr_ready,
	output logic                push,
	output flow_pkg::rec_t      push_rec,
	input  logic                credit_ret
);

	localparam flow_pkg::credit_t CREDIT_INIT = flow_pkg::credit_t'(`DISP_FIFO_DEPTH);

	flow_pkg::credit_t credits;
	flow_pkg::rec_t    rec_in;
	logic              accept;

	assign wr_ready = (credits != '0); // a free buffer slot is guaranteed
	assign accept   = wr_en & wr_ready;

	always_comb begin
		rec_in.kind    = wr_kind;
		rec_in.payload = wr_data; // one byte, the kind says how the scanner reads it
	end

	// taken at acceptance, given back on the edge after each pop
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			credits <= CREDIT_INIT;
		end else begin
			case ({accept, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // both at once cancel
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			push <= 1'b0;
		end else begin
			push <= accept; // one cycle after the write
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			push_rec <= rec_in;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/credit_fifo.sv ====
`default_nettype none

`include "disp_params.svh"

module credit_fifo (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           push,
	input  flow_pkg::rec_t push_rec,
	input  logic           pop,
	output logic           rec_avail,
	output flow_pkg::rec_t head_rec,
	output logic           credit_ret
);

	localparam int DEPTH = `DISP_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

	flow_pkg::rec_t    mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	flow_pkg::credit_t count;
	logic              do_pop;

	// wraps at any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_LAST) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign rec_avail  = (count != '0);
	assign do_pop     = pop & rec_avail;
	assign credit_ret = do_pop; // same cycle as the pop
	assign head_rec   = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_rec;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
		end
	end

	// occupancy, the writer's credits keep it from going past depth
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			count <= '0;
		end else begin
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/digit_scanner.sv ====
`default_nettype none

`include "disp_params.svh"

module digit_scanner (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           rec_avail,
	input  flow_pkg::rec_t head_rec,
	output logic           pop,
	output disp_pkg::sel_t sel,
	output disp_pkg::seg_t seg_out
);

	localparam int TICKS  = `DISP_SCAN_TICKS;
	localparam int DIGITS = `DISP_DIGITS;
	localparam int TICK_W = (TICKS > 1) ? $clog2(TICKS) : 1;
	localparam int POS_W  = (DIGITS > 1) ? $clog2(DIGITS) : 1;
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS - 1);
	localparam logic [POS_W-1:0]  POS_LAST  = POS_W'(DIGITS - 1);

	logic [TICK_W-1:0]      tick;
	logic [POS_W-1:0]       pos;
	logic                   frame_end;
	logic                   have_rec;
	logic                   next_valid;
	flow_pkg::rec_t         cur_rec;
	flow_pkg::rec_t         next_rec;
	disp_pkg::digit_array_t digits;
	disp_pkg::digit_array_t next_digits;
	logic [7:0]             value;
	logic [3:0]             hundreds;
	logic [3:0]             tens;
	logic [3:0]             units;

	// tick counts within a digit, pos walks the digits
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			tick <= '0;
			pos  <= '0;
		end else if (tick == TICK_LAST) begin
			tick <= '0;
			pos  <= (pos == POS_LAST) ? '0 : pos + 1'b1;
		end else begin
			tick <= tick + 1'b1;
		end
	end

	assign frame_end = (tick == TICK_LAST) && (pos == POS_LAST);
	assign pop       = frame_end & rec_avail; // at most one record per frame

	// the record for the coming frame, held over when the buffer is empty
	assign next_rec   = pop ? head_rec : cur_rec;
	assign next_valid = pop | have_rec;

	always_comb begin
		value    = next_rec.payload.value;
		hundreds = 4'(value / 8'd100);
		tens     = 4'((value / 8'd10) % 8'd10);
		units    = 4'(value % 8'd10);

		next_digits = {DIGITS{disp_pkg::SEG_BLANK}};
		if (next_valid) begin
			if (next_rec.kind == flow_pkg::REC_VALUE) begin
				next_digits    = {DIGITS{disp_pkg::SEG_ZERO}}; // upper digits read 0
				next_digits[2] = disp_pkg::seg_decode(hundreds);
				next_digits[1] = disp_pkg::seg_decode(tens);
				next_digits[0] = disp_pkg::seg_decode(units);
			end else begin
				next_digits[0] = next_rec.payload.pattern;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cur_rec <= head_rec;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			have_rec <= 1'b0;
			digits   <= {DIGITS{disp_pkg::SEG_BLANK}}; // dark until the first pop
		end else if (frame_end) begin
			have_rec <= next_valid;
			digits   <= next_digits;
		end
	end

	// outputs trail the counters by one cycle
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sel     <= '1;
			seg_out <= '1;
		end else begin
			sel     <= ~(disp_pkg::sel_t'(1) << pos);
			seg_out <= digits[pos];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/display_top.sv ====
`default_nettype none

module display_top (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                wr_en,
	input  flow_pkg::rec_kind_t wr_kind,
	input  logic [7:0]          wr_data,
	output logic                wr_ready,
	output disp_pkg::sel_t      sel,
	output disp_pkg::seg_t      seg_out
);

	logic           push;
	flow_pkg::rec_t push_rec;
	logic           credit_ret;
	logic           rec_avail;
	flow_pkg::rec_t head_rec;
	logic           pop;

	host_writer u_writer (
		.clk        (clk),
		.reset_n    (reset_n),
		.wr_en      (wr_en),
		.wr_kind    (wr_kind),
		.wr_data    (wr_data),
		.wr_ready   (wr_ready),
		.push       (push),
		.push_rec   (push_rec),
		.credit_ret (credit_ret)
	);

	credit_fifo u_fifo (
		.clk        (clk),
		.reset_n    (reset_n),
		.push       (push),
		.push_rec   (push_rec),
		.pop        (pop),
		.rec_avail  (rec_avail),
		.head_rec   (head_rec),
		.credit_ret (credit_ret)
	);

	digit_scanner u_scanner (
		.clk       (clk),
		.reset_n   (reset_n),
		.rec_avail (rec_avail),
		.head_rec  (head_rec),
		.pop       (pop),
		.sel       (sel),
		.seg_out   (seg_out)
	);

endmodule

`default_nettype wire

// ==== tb/display_vectors.svh ====
`ifndef DISPLAY_VECTORS_SVH
`define DISPLAY_VECTORS_SVH

// row columns are kind, data byte, gap before the write, expected digits
// digits hold position 5 in the top byte and position 0 in the bottom byte
// value rows read 0 on positions 3 to 5, pattern rows are blank on positions 1 to 5
// segments, active low: 0=C0 1=F9 2=A4 3=B0 4=99 5=92 6=82 7=F8 8=80 9=90

localparam int NUM_ROWS = 21;
localparam int RAND_GAP = -1; // gap of 0 to 7 cycles from the seeded generator

typedef struct packed {
	flow_pkg::rec_kind_t    kind;
	logic [7:0]             data;
	int                     gap;
	disp_pkg::digit_array_t digits;
} vec_t;

vec_t vectors [NUM_ROWS];

task automatic add_row(
	input int                     idx,
	input flow_pkg::rec_kind_t    kind,
	input logic [7:0]             data,
	input int                     gap,
	input disp_pkg::digit_array_t digits
);
	vectors[idx].kind   = kind;
	vectors[idx].data   = data;
	vectors[idx].gap    = gap;
	vectors[idx].digits = digits;
endtask

task automatic load_vectors();
	// decimal corner values
	add_row(0,  flow_pkg::REC_VALUE,   8'd0,    2,        48'hC0C0C0_C0C0C0);
	add_row(1,  flow_pkg::REC_VALUE,   8'd9,    1,        48'hC0C0C0_C0C090);
	add_row(2,  flow_pkg::REC_VALUE,   8'd10,   RAND_GAP, 48'hC0C0C0_C0F9C0);
	add_row(3,  flow_pkg::REC_VALUE,   8'd31,   5,        48'hC0C0C0_C0B0F9);
	add_row(4,  flow_pkg::REC_VALUE,   8'd99,   RAND_GAP, 48'hC0C0C0_C09090);
	add_row(5,  flow_pkg::REC_VALUE,   8'd100,  0,        48'hC0C0C0_F9C0C0);
	add_row(6,  flow_pkg::REC_VALUE,   8'd255,  3,        48'hC0C0C0_A49292);

	// raw patterns mixed with values
	add_row(7,  flow_pkg::REC_PATTERN, 8'h86,   40,       48'hFFFFFF_FFFF86);
	add_row(8,  flow_pkg::REC_VALUE,   8'd42,   0,        48'hC0C0C0_C099A4);
	add_row(9,  flow_pkg::REC_PATTERN, 8'hC7,   RAND_GAP, 48'hFFFFFF_FFFFC7);

	// burst with no gaps, runs the credits out
	add_row(10, flow_pkg::REC_VALUE,   8'd123,  30,       48'hC0C0C0_F9A4B0);
	add_row(11, flow_pkg::REC_VALUE,   8'd200,  0,        48'hC0C0C0_A4C0C0);
	add_row(12, flow_pkg::REC_VALUE,   8'd7,    0,        48'hC0C0C0_C0C0F8);
	add_row(13, flow_pkg::REC_VALUE,   8'd58,   0,        48'hC0C0C0_C09280);
	add_row(14, flow_pkg::REC_VALUE,   8'd64,   0,        48'hC0C0C0_C08299);
	add_row(15, flow_pkg::REC_VALUE,   8'd250,  0,        48'hC0C0C0_A492C0);

	// long pause so the buffer drains and 250 repeats
	add_row(16, flow_pkg::REC_VALUE,   8'd186,  160,      48'hC0C0C0_F98082);
	add_row(17, flow_pkg::REC_VALUE,   8'd77,   RAND_GAP, 48'hC0C0C0_C0F8F8);
	add_row(18, flow_pkg::REC_VALUE,   8'd138,  RAND_GAP, 48'hC0C0C0_F9B080);

	// same byte as the 5 pattern, then the value 5
	add_row(19, flow_pkg::REC_PATTERN, 8'h92,   2,        48'hFFFFFF_FFFF92);
	add_row(20, flow_pkg::REC_VALUE,   8'd5,    0,        48'hC0C0C0_C0C092);
endtask

`endif

// ==== tb/tb_display.sv ====
`default_nettype none

`include "disp_params.svh"

module tb_display;

	localparam int CLK_PERIOD     = 8;
	localparam int TICKS          = `DISP_SCAN_TICKS;
	localparam int DIGITS         = `DISP_DIGITS;
	localparam int DEPTH          = `DISP_FIFO_DEPTH;
	localparam int FRAME_CYCLES   = DIGITS * TICKS;
	localparam int ACCEPT_TO_SHOW = 4; // negedges from the last sample before acceptance to display

	`include "display_vectors.svh"

	localparam int WATCHDOG_CYCLES = (NUM_ROWS + 4) * FRAME_CYCLES * (DEPTH + 1);

	logic                clk;
	logic                reset_n;
	logic                wr_en;
	flow_pkg::rec_kind_t wr_kind;
	logic [7:0]          wr_data;
	logic                wr_ready;
	disp_pkg::sel_t      sel;
	disp_pkg::seg_t      seg_out;

	integer seed;
	int     drive_row;

	// reference model, one entry per accepted write
	int                     cyc          = 0;
	int                     pend_stamp[$];
	int                     pend_row[$];
	disp_pkg::digit_array_t cur_exp      = '1; // blank until the first record
	disp_pkg::digit_array_t frame_seen   = '1;
	logic                   have_cur     = 1'b0;
	logic                   frame_repeat = 1'b0;
	logic                   scan_started = 1'b0;
	logic                   ready_low    = 1'b0;
	int                     scan_pos     = 0;
	int                     scan_tick    = 0;
	int                     shown_rows   = 0;
	int                     frames_done  = 0;
	int                     hold_frames  = 0;

	display_top uut (
		.clk      (clk),
		.reset_n  (reset_n),
		.wr_en    (wr_en),
		.wr_kind  (wr_kind),
		.wr_data  (wr_data),
		.wr_ready (wr_ready),
		.sel      (sel),
		.seg_out  (seg_out)
	);

	task automatic stop_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [47:0] expected,
			input logic [47:0] actual);
		$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("%0t %s", $time, what);
		stop_with_failure();
	endtask

	// a record is shown once it has sat in the buffer through a frame end
	task automatic take_next_record();
		int dropped;
		frame_repeat = have_cur;
		if (pend_row.size() > 0 && pend_stamp[0] <= cyc - ACCEPT_TO_SHOW) begin
			cur_exp      = vectors[pend_row[0]].digits;
			dropped      = pend_row.pop_front();
			dropped      = pend_stamp.pop_front();
			have_cur     = 1'b1;
			frame_repeat = 1'b0;
			shown_rows   = shown_rows + 1;
		end
	endtask

	task automatic close_frame();
		assert (frame_seen == cur_exp) else report_mismatch("seg_out frame", cur_exp, frame_seen);
		if (frame_repeat) begin
			hold_frames = hold_frames + 1;
		end
		frames_done = frames_done + 1;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk) begin : monitor
		disp_pkg::sel_t exp_sel;
		if (!reset_n) begin
			assert (sel == '1) else report_mismatch("sel", disp_pkg::sel_t'('1), sel);
			assert (seg_out == '1) else report_mismatch("seg_out", 8'hFF, seg_out);
		end else if (!scan_started && sel == '1) begin
			assert (seg_out == '1) else report_mismatch("seg_out", 8'hFF, seg_out);
		end else begin
			if (!scan_started) begin
				scan_started = 1'b1;
				scan_pos     = 0;
				scan_tick    = 0;
				take_next_record();
			end else begin
				scan_tick = scan_tick + 1;
				if (scan_tick == TICKS) begin
					scan_tick = 0;
					scan_pos  = scan_pos + 1;
				end
				if (scan_pos == DIGITS) begin
					close_frame();
					scan_pos = 0;
					take_next_record();
				end
			end
			exp_sel           = '1;
			exp_sel[scan_pos] = 1'b0;
			assert (sel == exp_sel) else report_mismatch("sel", exp_sel, sel);
			if (scan_tick == 0) begin
				frame_seen[scan_pos] = seg_out;
			end else begin
				assert (seg_out == frame_seen[scan_pos])
				else report_mismatch("seg_out", frame_seen[scan_pos], seg_out);
			end
		end

		if (reset_n) begin
			// credits: wr_ready falls only with a full buffer's worth outstanding
			assert (pend_row.size() <= DEPTH)
			else report_problem("more records outstanding than the buffer can hold");
			if (pend_row.size() < DEPTH) begin
				assert (wr_ready) else report_mismatch("wr_ready", 1'b1, wr_ready);
			end
			if (!wr_ready) begin
				ready_low = 1'b1;
				assert (pend_row.size() == DEPTH)
				else report_mismatch("outstanding records", DEPTH, pend_row.size());
			end
			if (wr_en && wr_ready) begin
				pend_stamp.push_back(cyc);
				pend_row.push_back(drive_row);
			end
		end
		cyc = cyc + 1;
	end

	initial begin : driver
		int i;
		int gap;
		int frames_goal;
		seed      = 32'h3a3;
		reset_n   = 1'b0;
		wr_en     = 1'b0;
		wr_kind   = flow_pkg::REC_VALUE;
		wr_data   = 8'h00;
		drive_row = 0;
		load_vectors();

		repeat (2) @(posedge clk);
		reset_n <= 1'b1;

		for (i = 0; i < NUM_ROWS; i++) begin
			gap = vectors[i].gap;
			if (gap < 0) begin
				gap = $random(seed) & 7;
			end
			if (gap > 0) begin
				wr_en <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			wr_en     <= 1'b1;
			wr_kind   <= vectors[i].kind;
			wr_data   <= vectors[i].data;
			drive_row <= i;
			@(negedge clk);
			while (!wr_ready) @(negedge clk); // hold the write until a credit is back
			@(posedge clk);
		end
		wr_en <= 1'b0;

		wait (shown_rows == NUM_ROWS);
		frames_goal = frames_done + 3;
		wait (frames_done >= frames_goal); // last record should keep repeating

		assert (hold_frames > 0)
		else report_problem("no record was held over while the buffer was empty");
		assert (ready_low) else report_problem("wr_ready never fell during the burst");
		$display("*** PASSED ***");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before all records were shown",
			WATCHDOG_CYCLES);
		stop_with_failure();
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
+incdir+tb
rtl/disp_pkg.sv
rtl/flow_pkg.sv
rtl/host_writer.sv
rtl/credit_fifo.sv
rtl/digit_scanner.sv
rtl/display_top.sv
tb/tb_display.sv
